//--- axi_master/axi_read_master.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_master import bus_pkg::*, axi_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                rd_req_i,
    input  wire logic [ID_W-1:0]     rd_id_i,
    input  wire logic [ADDR_W-1:0]   rd_addr_i,
    input  wire size_t               rd_size_i,
    output logic                     rd_done_o,
    output logic [DATA_W-1:0]        rd_data_o,
    // AR channel
    output logic                     arvalid_o,
    input  wire logic                arready_i,
    output logic [ID_W-1:0]          arid_o,
    output logic [ADDR_W-1:0]        araddr_o,
    output logic [LEN_W-1:0]         arlen_o,
    output logic [AXSIZE_W-1:0]      arsize_o,
    output logic [BURST_W-1:0]       arburst_o,
    // R channel
    input  wire logic                rvalid_i,
    output logic                     rready_o,
    input  wire logic [DATA_W-1:0]   rdata_i,
    input  wire logic [ID_W-1:0]     rid_i,
    input  wire logic [RESP_W-1:0]   rresp_i
);

    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_t;

    rd_state_t state_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= RD_IDLE;
            rd_done_o <= 1'b0;
        end else begin
            rd_done_o <= 1'b0;
            case (state_q)
                RD_IDLE: if (rd_req_i)  state_q <= RD_ADDR;
                RD_ADDR: if (arready_i) state_q <= RD_DATA;
                RD_DATA: begin
                    if (rvalid_i) begin
                        state_q   <= RD_IDLE;
                        rd_done_o <= 1'b1;          // single-cycle done
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == RD_DATA && rvalid_i) begin
            rd_data_o <= rdata_i;                   // held for the done cycle
        end
    end

    // request fields are held by the arbiter during the transfer
    assign arvalid_o = (state_q == RD_ADDR);
    assign arid_o    = rd_id_i;
    assign araddr_o  = align_addr(rd_addr_i, rd_size_i);
    assign arlen_o   = '0;                          // single beat
    assign arsize_o  = {1'b0, rd_size_i};
    assign arburst_o = BURST_INCR;
    assign rready_o  = 1'b1;

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        (arvalid_o && !arready_i) |=> (arvalid_o && $stable(araddr_o) && $stable(arid_o)));

    a_rid_match: assert property (@(posedge clk) disable iff (rst)
        (rvalid_i && rready_o) |-> (rid_i == arid_o && rresp_i == RESP_OKAY));

endmodule

`default_nettype wire

//--- axi_master/axi_write_master.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_master import bus_pkg::*, axi_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                wr_req_i,
    input  wire logic [ADDR_W-1:0]   wr_addr_i,
    input  wire size_t               wr_size_i,
    input  wire logic [DATA_W-1:0]   wr_wdata_i,
    output logic                     wr_done_o,
    // AW channel
    output logic                     awvalid_o,
    input  wire logic                awready_i,
    output logic [ID_W-1:0]          awid_o,
    output logic [ADDR_W-1:0]        awaddr_o,
    output logic [LEN_W-1:0]         awlen_o,
    output logic [AXSIZE_W-1:0]      awsize_o,
    output logic [BURST_W-1:0]       awburst_o,
    // W channel
    output logic                     wvalid_o,
    input  wire logic                wready_i,
    output logic [DATA_W-1:0]        wdata_o,
    output logic [STRB_W-1:0]        wstrb_o,
    output logic                     wlast_o,
    // B channel
    input  wire logic                bvalid_i,
    output logic                     bready_o,
    input  wire logic [RESP_W-1:0]   bresp_i
);

    typedef enum logic [1:0] {WR_IDLE, WR_SEND, WR_RESP} wr_state_t;

    wr_state_t         state_q;
    logic              aw_left;
    logic              w_left;
    logic [STRB_W-1:0] strb_run;

    // channels still waiting after this cycle
    assign aw_left = awvalid_o && !awready_i;
    assign w_left  = wvalid_o && !wready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= WR_IDLE;
            awvalid_o <= 1'b0;
            wvalid_o  <= 1'b0;
            wr_done_o <= 1'b0;
        end else begin
            wr_done_o <= 1'b0;
            case (state_q)
                WR_IDLE: begin
                    if (wr_req_i) begin
                        state_q   <= WR_SEND;
                        awvalid_o <= 1'b1;          // AW and W go out together
                        wvalid_o  <= 1'b1;
                    end
                end
                WR_SEND: begin
                    awvalid_o <= aw_left;
                    wvalid_o  <= w_left;
                    if (!aw_left && !w_left) state_q <= WR_RESP;
                end
                WR_RESP: begin
                    if (bvalid_i) begin
                        state_q   <= WR_IDLE;
                        wr_done_o <= 1'b1;
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    always_comb begin
        case (wr_size_i)
            SIZE_B:  strb_run = 8'h01;
            SIZE_H:  strb_run = 8'h03;
            SIZE_W:  strb_run = 8'h0f;
            default: strb_run = 8'hff;
        endcase
    end

    // low bytes copied into every lane, strobe picks the live ones
    always_comb begin
        case (wr_size_i)
            SIZE_B:  wdata_o = {8{wr_wdata_i[7:0]}};
            SIZE_H:  wdata_o = {4{wr_wdata_i[15:0]}};
            SIZE_W:  wdata_o = {2{wr_wdata_i[31:0]}};
            default: wdata_o = wr_wdata_i;
        endcase
    end

    assign awaddr_o  = align_addr(wr_addr_i, wr_size_i);
    assign wstrb_o   = strb_run << awaddr_o[2:0];
    assign awid_o    = ID_DATA;
    assign awlen_o   = '0;
    assign awsize_o  = {1'b0, wr_size_i};
    assign awburst_o = BURST_INCR;
    assign wlast_o   = 1'b1;                        // every beat is the last
    assign bready_o  = 1'b1;

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        (awvalid_o && !awready_i) |=> (awvalid_o && $stable(awaddr_o)));

    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        (wvalid_o && !wready_i) |=> (wvalid_o && $stable(wdata_o) && $stable(wstrb_o)));

    a_bresp_ok: assert property (@(posedge clk) disable iff (rst)
        bvalid_i |-> bresp_i == RESP_OKAY);

endmodule

`default_nettype wire

//--- common/axi_pkg.sv
`default_nettype none

package axi_pkg;

    localparam int ID_W     = 4;
    localparam int LEN_W    = 8;
    localparam int AXSIZE_W = 3;
    localparam int BURST_W  = 2;
    localparam int RESP_W   = 2;

    localparam logic [ID_W-1:0] ID_FETCH = 4'd0;    // instruction fetch reads
    localparam logic [ID_W-1:0] ID_DATA  = 4'd1;    // load/store traffic

    localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;
    localparam logic [RESP_W-1:0]  RESP_OKAY  = 2'b00;

endpackage

`default_nettype wire

//--- common/bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 64;
    localparam int STRB_W    = DATA_W / 8;
    localparam int MEM_WORDS = 256;
    localparam int IDX_W     = $clog2(MEM_WORDS);   // word index is addr[IDX_W+2:3]

    // access size, log2 of the byte count
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } size_t;

    typedef enum logic [1:0] {
        GNT_IDLE  = 2'd0,
        GNT_FETCH = 2'd1,
        GNT_DATA  = 2'd2
    } grant_t;

    // clear the low address bits below the access size
    function automatic logic [ADDR_W-1:0] align_addr(logic [ADDR_W-1:0] addr, size_t size);
        logic [ADDR_W-1:0] mask;
        mask = ~((ADDR_W'(1) << size) - ADDR_W'(1));
        return addr & mask;
    endfunction

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_subsys -f vlog.f --Mdir obj_dir -o tb_mem_subsys
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_mem_subsys > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- sim/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import bus_pkg::*; ();

    localparam int TIMEOUT = 40;                 // cycles allowed per request

    logic              clk;
    logic              rst;
    logic              if_valid;
    logic [ADDR_W-1:0] if_addr;
    size_t             if_size;
    logic              if_ready;
    logic [DATA_W-1:0] if_data;
    logic              mem_valid;
    logic              mem_wen;
    logic [ADDR_W-1:0] mem_addr;
    size_t             mem_size;
    logic [DATA_W-1:0] mem_wdata;
    logic              mem_ready;
    logic [DATA_W-1:0] mem_rdata;

    logic [DATA_W-1:0] shadow [MEM_WORDS];       // expected memory contents
    logic [15:0]       lfsr_q;
    int                cycle_q;
    int                errors;
    int                err_mark;
    int                pass_count;
    int                fail_count;
    logic              timed_out;
    logic [ADDR_W-1:0] addr_a;
    logic [ADDR_W-1:0] addr_b;
    logic [DATA_W-1:0] word_a;
    logic [DATA_W-1:0] word_b;
    logic [DATA_W-1:0] got_f;
    logic [DATA_W-1:0] got_d;
    int                at_f;
    int                at_d;
    logic [63:0]       op;
    size_t             sz;

    mem_subsys_top dut0 (
        .clk(clk), .rst(rst),
        .if_valid_i(if_valid), .if_addr_i(if_addr), .if_size_i(if_size),
        .if_ready_o(if_ready), .if_data_o(if_data),
        .mem_valid_i(mem_valid), .mem_wen_i(mem_wen), .mem_addr_i(mem_addr),
        .mem_size_i(mem_size), .mem_wdata_i(mem_wdata),
        .mem_ready_o(mem_ready), .mem_rdata_o(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst) cycle_q <= 0;
        else cycle_q <= cycle_q + 1;
    end

    // a ready pulse answers a request that was up the cycle before
    assert property (@(posedge clk) disable iff (rst) if_ready |-> $past(if_valid))
    else begin
        errors++;
        $display("fetch ready pulsed with no fetch request pending");
    end

    assert property (@(posedge clk) disable iff (rst) mem_ready |-> $past(mem_valid))
    else begin
        errors++;
        $display("data ready pulsed with no data request pending");
    end

    assert property (@(posedge clk) disable iff (rst) if_ready |=> !if_ready)
    else begin
        errors++;
        $display("fetch ready stayed high for more than one cycle");
    end

    assert property (@(posedge clk) disable iff (rst) mem_ready |=> !mem_ready)
    else begin
        errors++;
        $display("data ready stayed high for more than one cycle");
    end

    // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [63:0] take_bits(int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic size_t pick_size();
        logic [63:0] v;
        v = take_bits(2);
        return size_t'(v[1:0]);
    endfunction

    // word index in bits 10:3, offset a multiple of the access size
    function automatic logic [ADDR_W-1:0] pick_addr(size_t s);
        logic [63:0] idx;
        logic [63:0] off;
        idx = take_bits(8);
        off = take_bits(3 - int'(s));
        return {21'd0, idx[7:0], 3'(off << s)};
    endfunction

    // byte i of the store data lands in lane offset+i
    task automatic shadow_store(logic [ADDR_W-1:0] addr, size_t s, logic [DATA_W-1:0] wdata);
        int nbytes;
        int lane;
        nbytes = 1 << s;
        for (int i = 0; i < nbytes; i++) begin
            lane = int'(addr[2:0]) + i;
            shadow[addr[10:3]][8*lane +: 8] = wdata[8*i +: 8];
        end
    endtask

    task automatic check_word(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
        assert (act == exp)
        else begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic end_test(string name);
        if (errors == err_mark) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d error(s)", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic finish_run();
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // a request that timed out ends the run
    initial begin
        @(posedge timed_out);
        finish_run();
    end

    task automatic fetch_read(input logic [ADDR_W-1:0] addr, input size_t s,
                              output logic [DATA_W-1:0] data, output int done_at);
        int waited;
        @(negedge clk);
        if_valid = 1'b1;
        if_addr  = addr;
        if_size  = s;
        waited   = 0;
        @(negedge clk);
        while (!if_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!if_ready) begin
            errors++;
            $display("fetch port gave no ready within %0d cycles at address %h", TIMEOUT, addr);
            timed_out = 1'b1;
            forever @(negedge clk);
        end else begin
            data     = if_data;
            done_at  = cycle_q;
            if_valid = 1'b0;                     // drop after the pulse
        end
    endtask

    task automatic data_access(input logic wen, input logic [ADDR_W-1:0] addr, input size_t s,
                               input logic [DATA_W-1:0] wdata,
                               output logic [DATA_W-1:0] rdata, output int done_at);
        int waited;
        @(negedge clk);
        mem_valid = 1'b1;
        mem_wen   = wen;
        mem_addr  = addr;
        mem_size  = s;
        mem_wdata = wdata;
        waited    = 0;
        @(negedge clk);
        while (!mem_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!mem_ready) begin
            errors++;
            $display("data port gave no ready within %0d cycles at address %h", TIMEOUT, addr);
            timed_out = 1'b1;
            forever @(negedge clk);
        end else begin
            rdata     = mem_rdata;
            done_at   = cycle_q;
            mem_valid = 1'b0;
            if (wen) shadow_store(addr, s, wdata);
        end
    endtask

    task automatic store(logic [ADDR_W-1:0] addr, size_t s, logic [DATA_W-1:0] wdata);
        logic [DATA_W-1:0] ignored;
        int                at;
        data_access(1'b1, addr, s, wdata, ignored, at);
    endtask

    task automatic load_check(string name, logic [ADDR_W-1:0] addr, size_t s);
        logic [DATA_W-1:0] got;
        int                at;
        data_access(1'b0, addr, s, '0, got, at);
        check_word(name, shadow[addr[10:3]], got);
    endtask

    task automatic fetch_check(string name, logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] got;
        int                at;
        fetch_read(addr, SIZE_W, got, at);
        check_word(name, shadow[addr[10:3]], got);
    endtask

    initial begin
        rst        = 1'b1;
        if_valid   = 1'b0;
        if_addr    = '0;
        if_size    = SIZE_W;
        mem_valid  = 1'b0;
        mem_wen    = 1'b0;
        mem_addr   = '0;
        mem_size   = SIZE_D;
        mem_wdata  = '0;
        lfsr_q     = 16'd2;
        errors     = 0;
        err_mark   = 0;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (10) begin
            @(negedge clk);
            assert (!if_ready && !mem_ready)
            else begin
                errors++;
                $display("a ready output went high while no request was raised");
            end
        end
        end_test("idle");

        addr_a = pick_addr(SIZE_D);
        store(addr_a, SIZE_D, take_bits(64));
        fetch_check("rw_fetch", addr_a);
        load_check("rw_data", addr_a, SIZE_D);
        end_test("rw_word");

        addr_b = pick_addr(SIZE_D);
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 8; off += (1 << s)) begin
                store(addr_b + off, size_t'(s), take_bits(64));
                load_check("sized_store", addr_b, SIZE_D);
            end
        end
        end_test("sized_store");

        fork
            fetch_read(addr_a, SIZE_W, got_f, at_f);
            data_access(1'b0, addr_b, SIZE_D, '0, got_d, at_d);
        join
        assert (at_d < at_f)
        else begin
            errors++;
            $display("fetch finished before the data read raised in the same cycle");
        end
        check_word("priority_data", shadow[addr_b[10:3]], got_d);
        check_word("priority_fetch", shadow[addr_a[10:3]], got_f);
        end_test("priority");

        addr_b = addr_a ^ 32'h8;                 // neighbouring word
        word_a = shadow[addr_a[10:3]];
        word_b = take_bits(64);
        fork
            fetch_read(addr_a, SIZE_W, got_f, at_f);
            store(addr_b, SIZE_D, word_b);
        join
        check_word("overlap_fetch", word_a, got_f);
        load_check("overlap_data", addr_b, SIZE_D);
        end_test("overlap");

        for (int n = 0; n < 200; n++) begin
            op     = take_bits(2);
            sz     = pick_size();
            addr_b = pick_addr(sz);
            if (op[1]) store(addr_b, sz, take_bits(64));
            else if (op[0]) load_check("random_data", addr_b, sz);
            else fetch_check("random_fetch", addr_b);
        end
        end_test("random_mix");

        finish_run();
    end

endmodule

`default_nettype wire

//--- src/axi_sram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram import bus_pkg::*, axi_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst,
    // read side
    input  wire logic                arvalid_i,
    output logic                     arready_o,
    input  wire logic [ID_W-1:0]     arid_i,
    input  wire logic [ADDR_W-1:0]   araddr_i,
    input  wire logic [LEN_W-1:0]    arlen_i,
    input  wire logic [AXSIZE_W-1:0] arsize_i,
    input  wire logic [BURST_W-1:0]  arburst_i,
    output logic                     rvalid_o,
    input  wire logic                rready_i,
    output logic [ID_W-1:0]          rid_o,
    output logic [DATA_W-1:0]        rdata_o,
    output logic [RESP_W-1:0]        rresp_o,
    output logic                     rlast_o,
    // write side
    input  wire logic                awvalid_i,
    output logic                     awready_o,
    input  wire logic [ID_W-1:0]     awid_i,
    input  wire logic [ADDR_W-1:0]   awaddr_i,
    input  wire logic [LEN_W-1:0]    awlen_i,
    input  wire logic [AXSIZE_W-1:0] awsize_i,
    input  wire logic [BURST_W-1:0]  awburst_i,
    input  wire logic                wvalid_i,
    output logic                     wready_o,
    input  wire logic [DATA_W-1:0]   wdata_i,
    input  wire logic [STRB_W-1:0]   wstrb_i,
    input  wire logic                wlast_i,
    output logic                     bvalid_o,
    input  wire logic                bready_i,
    output logic [ID_W-1:0]          bid_o,
    output logic [RESP_W-1:0]        bresp_o
);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic              ar_fire;
    logic              aw_fire;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign arready_o = !rvalid_o;                   // one read in flight
    assign awready_o = awvalid_i && wvalid_i && !bvalid_o;
    assign wready_o  = awready_o;                   // AW and W taken together
    assign ar_fire   = arvalid_i && arready_o;
    assign aw_fire   = awvalid_i && awready_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_o <= 1'b0;
            bvalid_o <= 1'b0;
        end else begin
            if (ar_fire) rvalid_o <= 1'b1;
            else if (rready_i) rvalid_o <= 1'b0;
            if (aw_fire) bvalid_o <= 1'b1;
            else if (bready_i) bvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata_o <= mem[araddr_i[IDX_W+2:3]];    // whole aligned word
            rid_o   <= arid_i;
        end
        if (aw_fire) begin
            bid_o <= awid_i;
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb_i[b]) mem[awaddr_i[IDX_W+2:3]][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
    end

    assign rresp_o = RESP_OKAY;
    assign bresp_o = RESP_OKAY;
    assign rlast_o = 1'b1;

    // single-beat INCR traffic only
    a_ar_single: assert property (@(posedge clk) disable iff (rst)
        arvalid_i |-> (arlen_i == '0 && arburst_i == BURST_INCR && arsize_i <= 3'd3));

    a_aw_single: assert property (@(posedge clk) disable iff (rst)
        awvalid_i |-> (awlen_i == '0 && awburst_i == BURST_INCR && awsize_i <= 3'd3));

    a_w_last: assert property (@(posedge clk) disable iff (rst)
        wvalid_i |-> wlast_i);

endmodule

`default_nettype wire

//--- src/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import bus_pkg::*, axi_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    // fetch requester
    input  wire logic              if_valid_i,
    input  wire logic [ADDR_W-1:0] if_addr_i,
    input  wire size_t             if_size_i,
    output logic                   if_ready_o,
    output logic [DATA_W-1:0]      if_data_o,
    // data requester
    input  wire logic              mem_valid_i,
    input  wire logic              mem_wen_i,
    input  wire logic [ADDR_W-1:0] mem_addr_i,
    input  wire size_t             mem_size_i,
    input  wire logic [DATA_W-1:0] mem_wdata_i,
    output logic                   mem_ready_o,
    output logic [DATA_W-1:0]      mem_rdata_o,
    // read master
    output logic                   rd_req_o,
    output logic [ID_W-1:0]        rd_id_o,
    output logic [ADDR_W-1:0]      rd_addr_o,
    output size_t                  rd_size_o,
    input  wire logic              rd_done_i,
    input  wire logic [DATA_W-1:0] rd_data_i,
    // write master
    output logic                   wr_req_o,
    output logic [ADDR_W-1:0]      wr_addr_o,
    output size_t                  wr_size_o,
    output logic [DATA_W-1:0]      wr_wdata_o,
    input  wire logic              wr_done_i
);

    grant_t grant_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= GNT_IDLE;
        end else begin
            case (grant_q)
                GNT_IDLE: begin
                    if (mem_valid_i && !mem_wen_i) begin
                        grant_q <= GNT_DATA;            // data read wins
                    end else if (if_valid_i) begin
                        grant_q <= GNT_FETCH;
                    end
                end
                default: begin
                    if (rd_done_i) begin
                        grant_q <= GNT_IDLE;            // free the channel after done
                    end
                end
            endcase
        end
    end

    // read channel follows the grant
    assign rd_req_o  = (grant_q != GNT_IDLE) && !rd_done_i;
    assign rd_id_o   = (grant_q == GNT_DATA) ? ID_DATA : ID_FETCH;
    assign rd_addr_o = (grant_q == GNT_DATA) ? mem_addr_i : if_addr_i;
    assign rd_size_o = (grant_q == GNT_DATA) ? mem_size_i : if_size_i;

    // stores always own the write channel
    assign wr_req_o   = mem_valid_i && mem_wen_i && !wr_done_i;
    assign wr_addr_o  = mem_addr_i;
    assign wr_size_o  = mem_size_i;
    assign wr_wdata_o = mem_wdata_i;

    assign if_ready_o  = (grant_q == GNT_FETCH) && rd_done_i;
    assign if_data_o   = (grant_q == GNT_FETCH) ? rd_data_i : '0;
    assign mem_ready_o = ((grant_q == GNT_DATA) && rd_done_i) || wr_done_i;
    assign mem_rdata_o = (grant_q == GNT_DATA) ? rd_data_i : '0;

    // one read completion reaches exactly one requester
    a_one_read_ready: assert property (@(posedge clk) disable iff (rst)
        rd_done_i |-> (if_ready_o ^ (grant_q == GNT_DATA)));

    // owner and its request are fixed for the whole read transfer
    a_grant_held: assert property (@(posedge clk) disable iff (rst)
        rd_req_o |=> ($stable(grant_q) && $stable(rd_addr_o) && $stable(rd_size_o)));

endmodule

`default_nettype wire

//--- src/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top import bus_pkg::*, axi_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              if_valid_i,
    input  wire logic [ADDR_W-1:0] if_addr_i,
    input  wire size_t             if_size_i,
    output logic                   if_ready_o,
    output logic [DATA_W-1:0]      if_data_o,
    input  wire logic              mem_valid_i,
    input  wire logic              mem_wen_i,
    input  wire logic [ADDR_W-1:0] mem_addr_i,
    input  wire size_t             mem_size_i,
    input  wire logic [DATA_W-1:0] mem_wdata_i,
    output logic                   mem_ready_o,
    output logic [DATA_W-1:0]      mem_rdata_o
);

    // arbiter to masters
    logic rd_req, rd_done, wr_req, wr_done;
    logic [ID_W-1:0]   rd_id;
    logic [ADDR_W-1:0] rd_addr, wr_addr;
    size_t             rd_size, wr_size;
    logic [DATA_W-1:0] rd_data, wr_wdata;

    // AXI read channels
    logic arvalid, arready, rvalid, rready;
    logic [ID_W-1:0]     arid, rid;
    logic [ADDR_W-1:0]   araddr;
    logic [LEN_W-1:0]    arlen;
    logic [AXSIZE_W-1:0] arsize;
    logic [BURST_W-1:0]  arburst;
    logic [DATA_W-1:0]   rdata;
    logic [RESP_W-1:0]   rresp;

    // AXI write channels
    logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [ID_W-1:0]     awid;
    logic [ADDR_W-1:0]   awaddr;
    logic [LEN_W-1:0]    awlen;
    logic [AXSIZE_W-1:0] awsize;
    logic [BURST_W-1:0]  awburst;
    logic [DATA_W-1:0]   wdata;
    logic [STRB_W-1:0]   wstrb;
    logic [RESP_W-1:0]   bresp;

    bus_arbiter arb0 (
        .clk, .rst,
        .if_valid_i, .if_addr_i, .if_size_i, .if_ready_o, .if_data_o,
        .mem_valid_i, .mem_wen_i, .mem_addr_i, .mem_size_i, .mem_wdata_i,
        .mem_ready_o, .mem_rdata_o,
        .rd_req_o(rd_req), .rd_id_o(rd_id), .rd_addr_o(rd_addr), .rd_size_o(rd_size),
        .rd_done_i(rd_done), .rd_data_i(rd_data),
        .wr_req_o(wr_req), .wr_addr_o(wr_addr), .wr_size_o(wr_size),
        .wr_wdata_o(wr_wdata), .wr_done_i(wr_done)
    );

    axi_read_master rdm0 (
        .clk, .rst,
        .rd_req_i(rd_req), .rd_id_i(rd_id), .rd_addr_i(rd_addr), .rd_size_i(rd_size),
        .rd_done_o(rd_done), .rd_data_o(rd_data),
        .arvalid_o(arvalid), .arready_i(arready), .arid_o(arid), .araddr_o(araddr),
        .arlen_o(arlen), .arsize_o(arsize), .arburst_o(arburst),
        .rvalid_i(rvalid), .rready_o(rready), .rdata_i(rdata), .rid_i(rid), .rresp_i(rresp)
    );

    axi_write_master wrm0 (
        .clk, .rst,
        .wr_req_i(wr_req), .wr_addr_i(wr_addr), .wr_size_i(wr_size),
        .wr_wdata_i(wr_wdata), .wr_done_o(wr_done),
        .awvalid_o(awvalid), .awready_i(awready), .awid_o(awid), .awaddr_o(awaddr),
        .awlen_o(awlen), .awsize_o(awsize), .awburst_o(awburst),
        .wvalid_o(wvalid), .wready_i(wready), .wdata_o(wdata), .wstrb_o(wstrb),
        .wlast_o(wlast), .bvalid_i(bvalid), .bready_o(bready), .bresp_i(bresp)
    );

    axi_sram sram0 (
        .clk, .rst,
        .arvalid_i(arvalid), .arready_o(arready), .arid_i(arid), .araddr_i(araddr),
        .arlen_i(arlen), .arsize_i(arsize), .arburst_i(arburst),
        .rvalid_o(rvalid), .rready_i(rready), .rid_o(rid), .rdata_o(rdata),
        .rresp_o(rresp), .rlast_o(),
        .awvalid_i(awvalid), .awready_o(awready), .awid_i(awid), .awaddr_i(awaddr),
        .awlen_i(awlen), .awsize_i(awsize), .awburst_i(awburst),
        .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wstrb_i(wstrb),
        .wlast_i(wlast), .bvalid_o(bvalid), .bready_i(bready), .bid_o(), .bresp_o(bresp)
    );

endmodule

`default_nettype wire

//--- vlog.f
common/bus_pkg.sv
common/axi_pkg.sv
src/bus_arbiter.sv
axi_master/axi_read_master.sv
axi_master/axi_write_master.sv
src/axi_sram.sv
src/mem_subsys_top.sv
sim/tb_mem_subsys.sv
